//--- hw/tlb_pkg.sv
package tlb_pkg;

   ////////////////////////////////////////////////
   // Address sizes

   localparam int VA_W   = 32;
   localparam int PA_W   = 36;
   localparam int PAGE_W = 12;                // 4 kB pages

   ////////////////////////////////////////////////
   // Table geometry

   localparam int SETS     = 8;
   localparam int SET_W    = $clog2(SETS);
   localparam int OFFSETS  = 4;               // Entries per set per way
   localparam int OFFSET_W = $clog2(OFFSETS);
   localparam int WAYS     = 2;               // Compared in parallel
   localparam int WAY_W    = $clog2(WAYS);

   // Entry index within a way is {set, offset}
   localparam int ENTRY_W  = SET_W + OFFSET_W;
   localparam int VA_DEPTH = 2 ** ENTRY_W;

   // VA bits left after page offset and set index
   localparam int TAG_W = VA_W - PAGE_W - SET_W;
   localparam int PPN_W = PA_W - PAGE_W;

   // PA storage holds all ways, indexed by {entry, way}
   localparam int PA_IDX_W = ENTRY_W + WAY_W;
   localparam int PA_DEPTH = 2 ** PA_IDX_W;

   ////////////////////////////////////////////////
   // VA word layout

   localparam int VALID_BIT = 0;
   localparam int WR_BIT    = 1;               // Entry is writable
   localparam int TAG_LSB   = 2;

   ////////////////////////////////////////////////
   // Configuration port

   localparam int CFG_ADDR_W  = 9;
   localparam int CFG_DATA_W  = 32;
   localparam int CFG_SEL_BIT = CFG_ADDR_W - 1; // 0 selects VA, 1 selects PA

   // VA write address: [WAY_W-1:0] way, then ENTRY_W bits of entry
   localparam int CFG_VA_ENTRY_LSB = WAY_W;

   ////////////////////////////////////////////////
   // Enums

   typedef enum logic [1:0] {
      S_IDLE,
      S_SEARCH,
      S_WAIT
   } search_state_e;

   typedef enum logic [1:0] {
      R_HIT,
      R_MISS,
      R_PROT,
      R_MULTI
   } result_e;

endpackage

//--- hw/tlb_search_ctrl.sv
module tlb_search_ctrl (
   input  logic                       clk_i,
   input  logic                       rst_ni,
   // Request
   input  logic                       lookup_i,
   input  logic [tlb_pkg::VA_W-1:0]    va_i,
   input  logic                       write_i,
   // From resolve stage
   input  logic                       stop_i,
   input  logic                       done_i,
   // To the ways
   output logic [tlb_pkg::ENTRY_W-1:0] rd_entry_o,
   output logic                       rd_valid_o,
   output logic                       rd_last_o,
   output logic [tlb_pkg::TAG_W-1:0]   tag_o,
   output logic                       write_o,
   // Status
   output logic [tlb_pkg::PAGE_W-1:0]  page_off_o,
   output logic                       busy_o
);

   import tlb_pkg::*;

   search_state_e         state_q, state_d;
   logic [OFFSET_W-1:0]   off_q;
   logic [VA_W-1:0]       va_q;
   logic                  write_q;
   logic                  accept;
   logic [SET_W-1:0]      set_idx;

   ////////////////////////////////////////////////
   // Request capture

   // Busy drops with done, so a request in the result cycle is taken
   assign busy_o = (state_q != S_IDLE) && !done_i;
   assign accept = lookup_i && !busy_o;

   always_ff @(posedge clk_i) begin
      if (accept) begin
         va_q    <= va_i;
         write_q <= write_i;
      end
   end

   assign set_idx    = va_q[PAGE_W +: SET_W];
   assign tag_o      = va_q[VA_W-1 -: TAG_W];
   assign page_off_o = va_q[PAGE_W-1:0];
   assign write_o    = write_q;

   ////////////////////////////////////////////////
   // FSM

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         S_IDLE: begin
            if (accept) state_d = S_SEARCH;
         end
         S_SEARCH: begin
            // Decisive flags or nothing left to issue
            if (stop_i || rd_last_o) state_d = S_WAIT;
         end
         S_WAIT: begin
            if (done_i) state_d = accept ? S_SEARCH : S_IDLE;
         end
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   ////////////////////////////////////////////////
   // Offset walk

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         off_q <= '0;
      end else if (accept) begin
         off_q <= '0;                  // Always start at offset 0
      end else if (rd_valid_o) begin
         off_q <= off_q + 1'b1;
      end
   end

   // Stop kills the issue of the current cycle
   assign rd_valid_o = (state_q == S_SEARCH) && !stop_i;
   assign rd_last_o  = (off_q == OFFSET_W'(OFFSETS - 1));
   assign rd_entry_o = {set_idx, off_q};   // set * OFFSETS + offset

   ////////////////////////////////////////////////
   // Assertions

   a_no_lookup_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
      lookup_i |-> !busy_o);

   // Resolve only finishes a search this stage has closed
   a_done_in_wait : assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_i |-> state_q == S_WAIT);

endmodule

//--- hw/tlb_way.sv
module tlb_way #(
   parameter int WAY_IDX = 0
) (
   input  logic                          clk_i,
   input  logic                          rst_ni,
   // Configuration writes
   input  logic                          cfg_we_i,
   input  logic [tlb_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [tlb_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
   // From issue stage
   input  logic [tlb_pkg::ENTRY_W-1:0]    rd_entry_i,
   input  logic                          rd_valid_i,
   input  logic                          rd_last_i,
   input  logic [tlb_pkg::TAG_W-1:0]      tag_i,
   input  logic                          write_i,
   // Flags to resolve stage
   output logic                          match_o,
   output logic                          deny_o,
   output logic                          flag_valid_o,
   output logic                          flag_last_o,
   output logic [tlb_pkg::ENTRY_W-1:0]    entry_o
);

   import tlb_pkg::*;

   logic [CFG_DATA_W-1:0]  va_mem [VA_DEPTH];
   logic                   va_we;
   logic [ENTRY_W-1:0]     wr_entry;

   // Read stage
   logic [CFG_DATA_W-1:0]  rd_word_q;
   logic                   rd_valid_q;
   logic                   rd_last_q;
   logic [ENTRY_W-1:0]     rd_entry_q;

   // Compare
   logic                   tag_hit;
   logic                   wr_denied;

   ////////////////////////////////////////////////
   // VA storage

   // Selector 0 and our way number
   assign va_we    = cfg_we_i && !cfg_addr_i[CFG_SEL_BIT]
                     && (cfg_addr_i[WAY_W-1:0] == WAY_W'(WAY_IDX));
   assign wr_entry = cfg_addr_i[CFG_VA_ENTRY_LSB +: ENTRY_W];

   always_ff @(posedge clk_i) begin
      if (va_we) begin
         va_mem[wr_entry] <= cfg_wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_valid_i) begin
         rd_word_q <= va_mem[rd_entry_i];  // Synchronous read
      end
      rd_last_q  <= rd_last_i;
      rd_entry_q <= rd_entry_i;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_valid_i;
      end
   end

   ////////////////////////////////////////////////
   // Tag compare

   assign tag_hit   = rd_word_q[VALID_BIT] && (rd_word_q[TAG_LSB +: TAG_W] == tag_i);
   assign wr_denied = tag_hit && write_i && !rd_word_q[WR_BIT];

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         flag_valid_o <= 1'b0;
         match_o      <= 1'b0;
         deny_o       <= 1'b0;
      end else begin
         flag_valid_o <= rd_valid_q;
         match_o      <= rd_valid_q && tag_hit;  // Killed reads never match
         deny_o       <= rd_valid_q && wr_denied;
      end
   end

   always_ff @(posedge clk_i) begin
      flag_last_o <= rd_last_q;
      entry_o     <= rd_entry_q;
   end

endmodule

//--- hw/tlb_resolve.sv
module tlb_resolve (
   input  logic                                        clk_i,
   input  logic                                        rst_ni,
   // Configuration writes
   input  logic                                        cfg_we_i,
   input  logic [tlb_pkg::CFG_ADDR_W-1:0]               cfg_addr_i,
   input  logic [tlb_pkg::CFG_DATA_W-1:0]               cfg_wdata_i,
   // Flags from the ways
   input  logic [tlb_pkg::WAYS-1:0]                     match_i,
   input  logic [tlb_pkg::WAYS-1:0]                     deny_i,
   input  logic [tlb_pkg::WAYS-1:0]                     flag_valid_i,
   input  logic [tlb_pkg::WAYS-1:0]                     flag_last_i,
   input  logic [tlb_pkg::WAYS-1:0][tlb_pkg::ENTRY_W-1:0] entry_i,
   // From issue stage
   input  logic [tlb_pkg::PAGE_W-1:0]                   page_off_i,
   // To issue stage
   output logic                                        stop_o,
   output logic                                        done_o,
   // Result
   output logic                                        hit_o,
   output logic                                        miss_o,
   output logic                                        prot_o,
   output logic                                        multi_hit_o,
   output logic [tlb_pkg::PA_W-1:0]                     pa_o
);

   import tlb_pkg::*;

   logic [PPN_W-1:0]     pa_mem [PA_DEPTH];
   logic                 pa_we;
   logic [PA_IDX_W-1:0]  pa_rd_idx;
   logic [PPN_W-1:0]     ppn_q;

   logic                 flags_in;
   logic                 last_in;
   logic [WAY_W:0]       n_match;
   logic [WAY_W-1:0]     hit_way;
   result_e              res_d, res_q;
   logic                 done_q;

   ////////////////////////////////////////////////
   // Merge way flags

   // Late flags of an already finished search are dropped
   assign flags_in = |flag_valid_i && !done_q;
   assign last_in  = |(flag_last_i & flag_valid_i);

   always_comb begin
      n_match = '0;
      hit_way = '0;
      for (int w = 0; w < WAYS; w++) begin
         n_match = n_match + (WAY_W + 1)'(match_i[w]);
         if (match_i[w]) hit_way = WAY_W'(w);
      end
   end

   // Priority: multi, then prot, then hit
   always_comb begin
      if (n_match > 1) begin
         res_d = R_MULTI;
      end else if (|deny_i) begin
         res_d = R_PROT;
      end else if (n_match == 1) begin
         res_d = R_HIT;
      end else begin
         res_d = R_MISS;
      end
   end

   assign stop_o = flags_in && ((n_match != 0) || last_in);

   ////////////////////////////////////////////////
   // Result register

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         done_q <= 1'b0;
         res_q  <= R_MISS;
      end else begin
         done_q <= stop_o;          // One-cycle pulse
         if (stop_o) res_q <= res_d;
      end
   end

   assign done_o      = done_q;
   assign hit_o       = done_q && (res_q == R_HIT);
   assign miss_o      = done_q && (res_q == R_MISS);
   assign prot_o      = done_q && (res_q == R_PROT);
   assign multi_hit_o = done_q && (res_q == R_MULTI);

   ////////////////////////////////////////////////
   // PA storage

   assign pa_we     = cfg_we_i && cfg_addr_i[CFG_SEL_BIT];
   assign pa_rd_idx = {entry_i[hit_way], hit_way};   // entry * WAYS + way

   always_ff @(posedge clk_i) begin
      if (pa_we) begin
         pa_mem[cfg_addr_i[PA_IDX_W-1:0]] <= cfg_wdata_i[PPN_W-1:0];
      end
   end

   // Read alongside the result register
   always_ff @(posedge clk_i) begin
      if (stop_o) begin
         ppn_q <= pa_mem[pa_rd_idx];
      end
   end

   assign pa_o = {ppn_q, page_off_i};  // Offset held by the issue stage

   ////////////////////////////////////////////////
   // Assertions

   // All ways run in lockstep, so their flags arrive together
   a_flags_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
      flag_valid_i == '0 || flag_valid_i == '1);

   a_deny_has_match : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (deny_i & ~match_i) == '0);

endmodule

//--- hw/tlb_l2_top.sv
module tlb_l2_top (
   input  logic                          clk_i,
   input  logic                          rst_ni,
   // Lookup request
   input  logic                          lookup_i,
   input  logic [tlb_pkg::VA_W-1:0]       va_i,
   input  logic                          write_i,
   // Configuration writes
   input  logic                          cfg_we_i,
   input  logic [tlb_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [tlb_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
   // Status and result
   output logic                          busy_o,
   output logic                          hit_o,
   output logic                          miss_o,
   output logic                          prot_o,
   output logic                          multi_hit_o,
   output logic [tlb_pkg::PA_W-1:0]       pa_o
);

   import tlb_pkg::*;

   // Issue stage to ways
   logic [ENTRY_W-1:0]            rd_entry;
   logic                          rd_valid;
   logic                          rd_last;
   logic [TAG_W-1:0]              tag;
   logic                          write_req;
   logic [PAGE_W-1:0]             page_off;

   // Ways to resolve stage
   logic [WAYS-1:0]               way_match;
   logic [WAYS-1:0]               way_deny;
   logic [WAYS-1:0]               way_valid;
   logic [WAYS-1:0]               way_last;
   logic [WAYS-1:0][ENTRY_W-1:0]  way_entry;

   // Resolve stage back to issue stage
   logic                          stop;
   logic                          done;

   tlb_search_ctrl u_search_ctrl (
      .clk_i      ( clk_i     ),
      .rst_ni     ( rst_ni    ),
      .lookup_i   ( lookup_i  ),
      .va_i       ( va_i      ),
      .write_i    ( write_i   ),
      .stop_i     ( stop      ),
      .done_i     ( done      ),
      .rd_entry_o ( rd_entry  ),
      .rd_valid_o ( rd_valid  ),
      .rd_last_o  ( rd_last   ),
      .tag_o      ( tag       ),
      .write_o    ( write_req ),
      .page_off_o ( page_off  ),
      .busy_o     ( busy_o    )
   );

   for (genvar w = 0; w < WAYS; w++) begin : g_way
      tlb_way #(
         .WAY_IDX ( w )
      ) u_way (
         .clk_i        ( clk_i        ),
         .rst_ni       ( rst_ni       ),
         .cfg_we_i     ( cfg_we_i     ),
         .cfg_addr_i   ( cfg_addr_i   ),
         .cfg_wdata_i  ( cfg_wdata_i  ),
         .rd_entry_i   ( rd_entry     ),
         .rd_valid_i   ( rd_valid     ),
         .rd_last_i    ( rd_last      ),
         .tag_i        ( tag          ),
         .write_i      ( write_req    ),
         .match_o      ( way_match[w] ),
         .deny_o       ( way_deny[w]  ),
         .flag_valid_o ( way_valid[w] ),
         .flag_last_o  ( way_last[w]  ),
         .entry_o      ( way_entry[w] )
      );
   end

   tlb_resolve u_resolve (
      .clk_i        ( clk_i       ),
      .rst_ni       ( rst_ni      ),
      .cfg_we_i     ( cfg_we_i    ),
      .cfg_addr_i   ( cfg_addr_i  ),
      .cfg_wdata_i  ( cfg_wdata_i ),
      .match_i      ( way_match   ),
      .deny_i       ( way_deny    ),
      .flag_valid_i ( way_valid   ),
      .flag_last_i  ( way_last    ),
      .entry_i      ( way_entry   ),
      .page_off_i   ( page_off    ),
      .stop_o       ( stop        ),
      .done_o       ( done        ),
      .hit_o        ( hit_o       ),
      .miss_o       ( miss_o      ),
      .prot_o       ( prot_o      ),
      .multi_hit_o  ( multi_hit_o ),
      .pa_o         ( pa_o        )
   );

   // Table contents must not change under a running search
   a_cfg_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
      cfg_we_i |-> !busy_o);

endmodule

//--- tests/tlb_model.svh
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

////////////////////////////////////////////////////
// Shadow copy of the table, updated on every write

logic [CFG_DATA_W-1:0] shadow_va [WAYS][VA_DEPTH];
logic [PPN_W-1:0]      shadow_pa [WAYS][VA_DEPTH];

// Expected lookup result
// Offsets are scanned in order, and the first offset with any match decides
function automatic void ref_lookup(input  logic [VA_W-1:0] va,
                                   input  logic            wr,
                                   output result_e         kind,
                                   output logic [PA_W-1:0] pa);
   int                    set_idx;
   int                    entry;
   int                    n_match;
   int                    hit_way;
   logic                  deny;
   logic                  found;
   logic [CFG_DATA_W-1:0] word;
   set_idx = int'(va[PAGE_W +: SET_W]);
   kind    = R_MISS;
   pa      = '0;
   found   = 1'b0;
   for (int off = 0; off < OFFSETS && !found; off++) begin
      entry   = set_idx * OFFSETS + off;
      n_match = 0;
      hit_way = 0;
      deny    = 1'b0;
      for (int w = 0; w < WAYS; w++) begin
         word = shadow_va[w][entry];
         if (word[VALID_BIT] === 1'b1 && word[TAG_LSB +: TAG_W] === va[VA_W-1 -: TAG_W]) begin
            n_match++;
            hit_way = w;
            if (wr && !word[WR_BIT]) deny = 1'b1;  // Write to read-only page
         end
      end
      if (n_match > 0) begin
         found = 1'b1;
         if (n_match > 1)  kind = R_MULTI;
         else if (deny)    kind = R_PROT;
         else              kind = R_HIT;
         pa = {shadow_pa[hit_way][entry], va[PAGE_W-1:0]};
      end
   end
endfunction

`endif

//--- tests/tb_tlb_l2.sv
module tb_tlb_l2;

   timeunit 1ns;
   timeprecision 100ps;

   import tlb_pkg::*;

   localparam int DRIVE_DLY   = 10;
   localparam int TIMEOUT_CYC = 20;
   localparam int SWEEP_LEN   = 200;
   localparam int SWEEP_BATCH = 50;   // Table refilled between batches

   logic                  clk_i;
   logic                  rst_ni;
   logic                  lookup_i;
   logic [VA_W-1:0]       va_i;
   logic                  write_i;
   logic                  cfg_we_i;
   logic [CFG_ADDR_W-1:0] cfg_addr_i;
   logic [CFG_DATA_W-1:0] cfg_wdata_i;
   logic                  busy_o;
   logic                  hit_o;
   logic                  miss_o;
   logic                  prot_o;
   logic                  multi_hit_o;
   logic [PA_W-1:0]       pa_o;

   `include "tlb_model.svh"

   result_e         exp_kind_q [$];
   logic [PA_W-1:0] exp_pa_q [$];
   int              wait_cycles = 0;
   int              error_count = 0;
   int              test_errors = 0;
   int              check_count = 0;
   int              lookup_count = 0;
   int              test_count = 0;
   int              failed_tests = 0;

   tlb_l2_top u_tlb_l2_top (
      .clk_i       ( clk_i       ),
      .rst_ni      ( rst_ni      ),
      .lookup_i    ( lookup_i    ),
      .va_i        ( va_i        ),
      .write_i     ( write_i     ),
      .cfg_we_i    ( cfg_we_i    ),
      .cfg_addr_i  ( cfg_addr_i  ),
      .cfg_wdata_i ( cfg_wdata_i ),
      .busy_o      ( busy_o      ),
      .hit_o       ( hit_o       ),
      .miss_o      ( miss_o      ),
      .prot_o      ( prot_o      ),
      .multi_hit_o ( multi_hit_o ),
      .pa_o        ( pa_o        )
   );

   always #50 clk_i = ~clk_i;

   ////////////////////////////////////////////////////
   // Reporting and checks

   task automatic note_error();
      error_count++;
      test_errors++;
   endtask

   task automatic abort_run(input string why);
      $display("%s at %0t ns", why, $time);
      $display("TEST FAIL");
      $finish;
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      check_count++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, got);
         note_error();
      end
   endtask

   task automatic check_result(input result_e kind, input logic [PA_W-1:0] pa);
      check_bit("hit_o", kind == R_HIT, hit_o);
      check_bit("miss_o", kind == R_MISS, miss_o);
      check_bit("prot_o", kind == R_PROT, prot_o);
      check_bit("multi_hit_o", kind == R_MULTI, multi_hit_o);
      check_bit("busy_o", 1'b0, busy_o);  // Falls with the pulse
      if (kind == R_HIT) begin
         check_count++;
         if (pa_o !== pa) begin
            $display("** Error at %0t ns: pa_o expected 0x%09h, got 0x%09h", $time, pa, pa_o);
            note_error();
         end
      end
   endtask

   // Sampled on the falling edge, away from both drive and capture
   always @(negedge clk_i) begin : compare_results
      result_e         kind;
      logic [PA_W-1:0] pa;
      if (rst_ni) begin
         if (hit_o || miss_o || prot_o || multi_hit_o) begin
            if (exp_kind_q.size() == 0) begin
               $display("Result pulse at %0t ns with no lookup outstanding", $time);
               note_error();
            end else begin
               check_result(exp_kind_q.pop_front(), exp_pa_q.pop_front());
            end
            wait_cycles = 0;
         end else if (exp_kind_q.size() != 0) begin
            wait_cycles++;
         end
         if (wait_cycles > TIMEOUT_CYC) begin
            abort_run("Timeout, no result pulse for an outstanding lookup");
         end else if (lookup_i && !busy_o) begin
            ref_lookup(va_i, write_i, kind, pa);  // Accepted on the next edge
            exp_kind_q.push_back(kind);
            exp_pa_q.push_back(pa);
         end
      end
   end

   ////////////////////////////////////////////////////
   // Bus drivers

   task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr,
                            input logic [CFG_DATA_W-1:0] data);
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      @(posedge clk_i);
      #DRIVE_DLY;
      cfg_we_i = 1'b0;
   endtask

   task automatic write_va(input int way, input int entry, input logic valid,
                           input logic wr, input logic [TAG_W-1:0] tag);
      logic [CFG_ADDR_W-1:0] addr;
      logic [CFG_DATA_W-1:0] data;
      addr                      = '0;       // Selector 0 for VA
      addr[WAY_W-1:0]           = WAY_W'(way);
      addr[WAY_W +: ENTRY_W]    = ENTRY_W'(entry);
      data                      = '0;
      data[VALID_BIT]           = valid;
      data[WR_BIT]              = wr;
      data[TAG_LSB +: TAG_W]    = tag;
      cfg_write(addr, data);
      shadow_va[way][entry] = data;
   endtask

   task automatic write_pa(input int way, input int entry, input logic [PPN_W-1:0] ppn);
      logic [CFG_ADDR_W-1:0] addr;
      addr                          = '0;
      addr[CFG_SEL_BIT]             = 1'b1;
      addr[ENTRY_W+WAY_W-1:0]       = (ENTRY_W+WAY_W)'(entry * WAYS + way);
      cfg_write(addr, CFG_DATA_W'(ppn));
      shadow_pa[way][entry] = ppn;
   endtask

   task automatic clear_table();
      for (int w = 0; w < WAYS; w++) begin
         for (int e = 0; e < VA_DEPTH; e++) begin
            write_va(w, e, 1'b0, 1'b0, '0);
         end
      end
   endtask

   function automatic logic [VA_W-1:0] make_va(input logic [TAG_W-1:0] tag,
                                               input int set_idx,
                                               input logic [PAGE_W-1:0] page_off);
      return {tag, SET_W'(set_idx), page_off};
   endfunction

   task automatic issue_lookup(input logic [VA_W-1:0] va, input logic wr);
      int cnt;
      cnt = 0;
      while (busy_o && cnt < TIMEOUT_CYC) begin
         @(posedge clk_i);
         #DRIVE_DLY;
         cnt++;
      end
      if (busy_o) begin
         $display("Timeout, busy_o stayed high before a lookup at %0t ns", $time);
         note_error();
      end else begin
         lookup_i = 1'b1;
         va_i     = va;
         write_i  = wr;
         @(posedge clk_i);
         #DRIVE_DLY;
         lookup_i = 1'b0;
         lookup_count++;
      end
   endtask

   task automatic wait_done();
      int cnt;
      cnt = 0;
      while ((busy_o || exp_kind_q.size() != 0) && cnt < 2 * TIMEOUT_CYC) begin
         @(posedge clk_i);
         #DRIVE_DLY;
         cnt++;
      end
      if (busy_o || exp_kind_q.size() != 0) begin
         $display("Timeout, lookups still outstanding at %0t ns", $time);
         note_error();
      end
   endtask

   task automatic end_test(input string name);
      wait_done();
      test_count++;
      if (test_errors == 0) begin
         $display("%s: ok", name);
      end else begin
         failed_tests++;
         $display("%s: failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   ////////////////////////////////////////////////////
   // Tests

   task automatic run_hit_test();
      int               set_idx;
      int               entry;
      int               way;
      logic [TAG_W-1:0] tag;
      clear_table();
      for (int i = 0; i < 4; i++) begin
         set_idx = $urandom % SETS;
         entry   = set_idx * OFFSETS + $urandom % OFFSETS;
         way     = $urandom % WAYS;
         tag     = TAG_W'($urandom);
         write_va(way, entry, 1'b1, 1'b1, tag);
         write_pa(way, entry, PPN_W'($urandom));
         issue_lookup(make_va(tag, set_idx, PAGE_W'($urandom)), 1'b0);
         wait_done();
      end
      end_test("hit");
   endtask

   task automatic run_miss_test();
      int               set_idx;
      logic [TAG_W-1:0] tag;
      clear_table();
      set_idx = $urandom % SETS;
      tag     = TAG_W'($urandom);
      for (int w = 0; w < WAYS; w++) begin
         for (int off = 0; off < OFFSETS; off++) begin
            write_va(w, set_idx * OFFSETS + off, 1'b1, 1'b1, tag);
         end
      end
      issue_lookup(make_va(tag ^ TAG_W'(1), set_idx, PAGE_W'($urandom)), 1'b0);
      issue_lookup(make_va(tag, (set_idx + 1) % SETS, '0), 1'b1);  // Empty set
      end_test("miss");
   endtask

   task automatic run_prot_test();
      int               set_idx;
      int               entry;
      logic [TAG_W-1:0] tag;
      clear_table();
      set_idx = $urandom % SETS;
      entry   = set_idx * OFFSETS + 2;
      tag     = TAG_W'($urandom);
      write_va(1, entry, 1'b1, 1'b0, tag);      // Read-only page
      write_pa(1, entry, PPN_W'($urandom));
      issue_lookup(make_va(tag, set_idx, PAGE_W'($urandom)), 1'b1);
      issue_lookup(make_va(tag, set_idx, PAGE_W'($urandom)), 1'b0);
      end_test("protection");
   endtask

   task automatic run_multi_test();
      int               set_idx;
      int               entry;
      logic [TAG_W-1:0] tag;
      clear_table();
      set_idx = $urandom % SETS;
      entry   = set_idx * OFFSETS + $urandom % OFFSETS;
      tag     = TAG_W'($urandom);
      for (int w = 0; w < WAYS; w++) begin
         write_va(w, entry, 1'b1, 1'b1, tag);
         write_pa(w, entry, PPN_W'($urandom));
      end
      issue_lookup(make_va(tag, set_idx, PAGE_W'($urandom)), 1'b0);
      end_test("multi hit");
   endtask

   task automatic run_scan_order_test();
      int               set_idx;
      int               way;
      logic [TAG_W-1:0] tag;
      clear_table();
      set_idx = $urandom % SETS;
      way     = $urandom % WAYS;
      tag     = TAG_W'($urandom);
      write_va(way, set_idx * OFFSETS + 1, 1'b1, 1'b1, tag);
      write_pa(way, set_idx * OFFSETS + 1, PPN_W'($urandom));
      write_va(way, set_idx * OFFSETS + 3, 1'b1, 1'b1, tag);
      write_pa(way, set_idx * OFFSETS + 3, PPN_W'($urandom));
      issue_lookup(make_va(tag, set_idx, PAGE_W'($urandom)), 1'b0);
      end_test("scan order");
   endtask

   // Small tag pool so hits, misses and multi hits all show up
   task automatic fill_random_table(input logic [TAG_W-1:0] tag_base);
      for (int w = 0; w < WAYS; w++) begin
         for (int e = 0; e < VA_DEPTH; e++) begin
            write_va(w, e, 1'($urandom % 2), 1'($urandom % 2),
                     tag_base ^ TAG_W'($urandom % 4));
            write_pa(w, e, PPN_W'($urandom));
         end
      end
   endtask

   task automatic run_random_sweep();
      logic [TAG_W-1:0] tag_base;
      tag_base = TAG_W'($urandom);
      for (int b = 0; b < SWEEP_LEN / SWEEP_BATCH; b++) begin
         fill_random_table(tag_base);
         for (int i = 0; i < SWEEP_BATCH; i++) begin
            issue_lookup(make_va(tag_base ^ TAG_W'($urandom % 4), $urandom % SETS,
                                 PAGE_W'($urandom)), 1'($urandom % 2));
            if ($urandom % 4 == 0) wait_done();  // Otherwise back to back
         end
         wait_done();
      end
      end_test("random sweep");
   endtask

   initial begin : main_seq
      int unsigned seed;
      clk_i       = 1'b0;
      rst_ni      = 1'b0;
      lookup_i    = 1'b0;
      va_i        = '0;
      write_i     = 1'b0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = '0;
      cfg_wdata_i = '0;
      seed        = $urandom(78669);
      repeat (2) @(posedge clk_i);
      #DRIVE_DLY;
      rst_ni = 1'b1;

      run_hit_test();
      run_miss_test();
      run_prot_test();
      run_multi_test();
      run_scan_order_test();
      run_random_sweep();

      $display("%0d tests, %0d failed, %0d lookups, %0d checks, %0d errors",
               test_count, failed_tests, lookup_count, check_count, error_count);
      if (error_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- sim.f
+incdir+tests
hw/tlb_pkg.sv
hw/tlb_search_ctrl.sv
hw/tlb_way.sv
hw/tlb_resolve.sv
hw/tlb_l2_top.sv
tests/tb_tlb_l2.sv
